// ==== mmc5.f ====
hdl/mmc5_pkg.sv
hdl/mmc5_regs.sv
hdl/mmc5_prg_map.sv
hdl/mmc5_chr_map.sv
hdl/mmc5_scanline_irq.sv
hdl/mmc5.sv
+incdir+test
test/mmc5_tb.sv

// ==== Bender.yml ====
package:
  name: mmc5

sources:
  - hdl/mmc5_pkg.sv
  - hdl/mmc5_regs.sv
  - hdl/mmc5_prg_map.sv
  - hdl/mmc5_chr_map.sv
  - hdl/mmc5_scanline_irq.sv
  - hdl/mmc5.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/mmc5_tb.sv

// ==== test/mmc5_tb_tasks.svh ====
// MMC5 testbench bus tasks for CPU register access and a PPU scanline fetch model
`ifndef MMC5_TB_TASKS_SVH
`define MMC5_TB_TASKS_SVH

	// One strobed CPU write; the strobe lands every third clock
	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk);
		#1;
		cpu_addr = addr;
		cpu_din  = data;
		cpu_wr   = 1'b1;
		cpu_rd   = 1'b0;
		cpu_ce   = 1'b1;
		@(posedge clk);
		#1;
		cpu_ce = 1'b0;
		cpu_wr = 1'b0;
		@(posedge clk);
	endtask

	task automatic cpu_read(input logic [15:0] addr, output logic [7:0] data, output logic en);
		@(posedge clk);
		#1;
		cpu_addr = addr;
		cpu_rd   = 1'b1;
		cpu_wr   = 1'b0;
		cpu_ce   = 1'b1;
		#2;
		data = cpu_dout_o;  // Read mux is combinational
		en   = cpu_dout_en_o;
		@(posedge clk);
		#1;
		cpu_ce = 1'b0;
		cpu_rd = 1'b0;
		@(posedge clk);
	endtask

	// Each PPU read is a one-clock pulse and so gives one rising edge
	task automatic ppu_read(input logic [13:0] addr);
		@(posedge clk);
		#1;
		ppu_addr = addr;
		ppu_rd   = 1'b1;
		@(posedge clk);
		#1;
		ppu_rd = 1'b0;
	endtask

	// Three identical nametable reads, a fourth read, then tile fetches ending on a pattern
	task automatic ppu_scanline(input logic [13:0] nt_addr);
		repeat (3) ppu_read(nt_addr);
		ppu_read(nt_addr + 14'd1);
		for (int t = 0; t < 34; t++) begin
			ppu_read(14'h2000 | 14'(t));
			ppu_read(14'(t << 4));
		end
	endtask

`endif

// ==== test/mmc5_tb.sv ====
// MMC5 mapper testbench covering PRG, CHR, mirroring, multiplier and scanline IRQ
`timescale 1ns/1ps

module mmc5_tb;

	localparam int TEST_CYCLES = 140 + 60 + 120 + 60 + 60 + 700;  // Rough length of each test

	logic        clk = 1'b0;
	logic        arst_n;
	logic        cpu_ce, cpu_wr, cpu_rd;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_din;
	logic [7:0]  cpu_dout_o;
	logic        cpu_dout_en_o;
	logic [21:0] prg_addr_o;
	logic        prg_allow_o;
	logic [13:0] ppu_addr;
	logic        ppu_rd;
	logic [21:0] chr_addr_o;
	logic        vram_a10_o, vram_ce_o, irq_o;

	integer      seed = 32'h6a498665;
	string       test_name;
	int          errors = 0;
	int          errors_at_start;
	int          tests_passed = 0;
	int          tests_failed = 0;
	logic [7:0]  banks [4];
	logic [2:0]  ram_bank;
	logic [9:0]  chr_vals [12];
	logic [1:0]  upper;
	logic [7:0]  rd_data, mul_a, mul_b, mirr;
	logic        rd_en;
	logic [15:0] addr, product;
	logic [13:0] p;

	mmc5 DUT (
		.clk           (clk),
		.arst_n_i      (arst_n),
		.cpu_ce_i      (cpu_ce),
		.cpu_wr_i      (cpu_wr),
		.cpu_rd_i      (cpu_rd),
		.cpu_addr_i    (cpu_addr),
		.cpu_din_i     (cpu_din),
		.cpu_dout_o    (cpu_dout_o),
		.cpu_dout_en_o (cpu_dout_en_o),
		.prg_addr_o    (prg_addr_o),
		.prg_allow_o   (prg_allow_o),
		.ppu_addr_i    (ppu_addr),
		.ppu_rd_i      (ppu_rd),
		.chr_addr_o    (chr_addr_o),
		.vram_a10_o    (vram_a10_o),
		.vram_ce_o     (vram_ce_o),
		.irq_o         (irq_o)
	);

	always #4 clk = !clk;

	`include "mmc5_tb_tasks.svh"

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (expected === actual) else begin
			$display("CHECK FAILED %s %s: expected %0h actual %0h", test_name, what,
				expected, actual);
			errors++;
		end
	endtask

	task automatic start_test(input string name);
		test_name       = name;
		errors_at_start = errors;
	endtask

	task automatic finish_test();
		if (errors == errors_at_start) begin
			tests_passed++;
			$display("test %s: ok", test_name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", test_name, errors - errors_at_start);
		end
	endtask

	// Put an address on the CPU bus without a strobe, then let it settle
	task automatic present_cpu(input logic [15:0] a, input logic wr);
		@(posedge clk);
		#1;
		cpu_addr = a;
		cpu_wr   = wr;
		cpu_rd   = !wr;
		#2;
	endtask

	task automatic present_ppu(input logic [13:0] a);
		@(posedge clk);
		#1;
		ppu_addr = a;
		#2;
	endtask

	// Each mode gives every 8 kB window a register and a span in 8 kB units
	function automatic logic [21:0] expected_prg(input int mode, input logic [15:0] a);
		logic [7:0] r, b;
		int         span;
		span = 1;
		r    = banks[3] | 8'h80;  // Top window is always ROM
		if (a < 16'h8000) begin
			r = {5'b0, ram_bank};
		end else if (mode == 0) begin
			span = 4;
		end else if (mode == 1) begin
			span = 2;
			if (a < 16'hC000)
				r = banks[1];
		end else if (mode == 2) begin
			if (a < 16'hC000) begin
				span = 2;
				r    = banks[1];
			end else if (a < 16'hE000) begin
				r = banks[2];
			end
		end else if (a < 16'hE000) begin
			r = banks[a[14:13]];
		end
		b = (r & ~8'(span - 1)) | (8'(a[14:13]) & 8'(span - 1));
		if (b[7])
			return {2'b00, b[6:0], a[12:0]};
		return {6'b111100, b[2:0], a[12:0]};
	endfunction

	// Span in 1 kB units is 8, 4, 2 or 1; a window uses the last register of its span
	function automatic logic [21:0] expected_chr(input int mode, input logic [13:0] a,
		input logic use_b);
		int         span, idx;
		logic [9:0] page;
		span = 8 >> mode;
		if (use_b)
			idx = 8 + (int'(a[11:10]) | ((span > 4 ? 4 : span) - 1));
		else
			idx = int'(a[12:10]) | (span - 1);
		page = 10'(chr_vals[idx] * span) | 10'(a[12:10] & 3'(span - 1));
		return {2'b10, page, a[9:0]};
	endfunction

	initial begin
		#((2 * TEST_CYCLES + 16) * 8);
		$display("Timeout: the tests did not finish in time");
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		arst_n   = 1'b0;
		cpu_ce   = 1'b0;
		cpu_wr   = 1'b0;
		cpu_rd   = 1'b0;
		cpu_addr = '0;
		cpu_din  = '0;
		ppu_addr = '0;
		ppu_rd   = 1'b0;
		repeat (8) @(posedge clk);
		#1 arst_n = 1'b1;

		start_test("prg_banking");
		for (int mode = 0; mode < 4; mode++) begin
			for (int i = 0; i < 4; i++) begin
				banks[i] = $random(seed);
				cpu_write(16'h5114 + 16'(i), banks[i]);
			end
			ram_bank = $random(seed);
			cpu_write(16'h5113, {5'b0, ram_bank});
			cpu_write(16'h5100, 8'(mode));
			for (int w = 3; w < 8; w++) begin
				addr = (16'(w) << 13) | (16'($random(seed)) & 16'h1FFF);
				present_cpu(addr, 1'b0);
				check_value("prg_addr", expected_prg(mode, addr), prg_addr_o);
			end
		end
		finish_test();

		start_test("prg_protect");
		cpu_write(16'h5113, 8'h02);
		present_cpu(16'h6000, 1'b1);
		check_value("allow locked", 1'b0, prg_allow_o);
		cpu_write(16'h5102, 8'h02);
		present_cpu(16'h6000, 1'b1);
		check_value("allow half", 1'b0, prg_allow_o);
		cpu_write(16'h5103, 8'h01);
		present_cpu(16'h6010, 1'b1);
		check_value("allow unlocked", 1'b1, prg_allow_o);
		present_cpu(16'h6020, 1'b0);
		check_value("allow read", 1'b1, prg_allow_o);
		cpu_write(16'h5100, 8'h03);
		cpu_write(16'h5114, 8'h85);
		present_cpu(16'h8000, 1'b1);
		check_value("allow rom", 1'b0, prg_allow_o);
		present_cpu(16'hE000, 1'b1);
		check_value("allow top rom", 1'b0, prg_allow_o);
		present_cpu(16'hE000, 1'b0);
		check_value("allow rom read", 1'b1, prg_allow_o);
		cpu_wr = 1'b0;
		finish_test();

		start_test("chr_banking");
		upper = $random(seed);
		cpu_write(16'h5130, {6'b0, upper});
		for (int i = 0; i < 12; i++) begin
			chr_vals[i] = {upper, 8'($random(seed))};
			cpu_write(16'h5120 + 16'(i), chr_vals[i][7:0]);
		end
		for (int mode = 3; mode > 0; mode -= 2) begin
			cpu_write(16'h5101, 8'(mode));
			for (int s = 0; s < 8; s++) begin
				p = (14'(s) << 10) | 14'($random(seed) & 10'h3FF);
				present_ppu(p);
				check_value("chr set A", expected_chr(mode, p, 1'b0), chr_addr_o);
			end
		end
		cpu_write(16'h5101, 8'h03);
		cpu_write(16'h2000, 8'h20);  // 8x16 sprites
		for (int i = 8; i < 12; i++) begin
			chr_vals[i] = {upper, 8'($random(seed))};
			cpu_write(16'h5120 + 16'(i), chr_vals[i][7:0]);
		end
		for (int s = 0; s < 8; s++) begin
			p = (14'(s) << 10) | 14'(s * 37);
			present_ppu(p);
			check_value("chr set B", expected_chr(3, p, 1'b1), chr_addr_o);
		end
		finish_test();

		start_test("multiplier");
		for (int i = 0; i < 3; i++) begin
			mul_a = $random(seed);
			mul_b = $random(seed);
			product = mul_a * mul_b;
			cpu_write(16'h5205, mul_a);
			cpu_write(16'h5206, mul_b);
			cpu_read(16'h5205, rd_data, rd_en);
			check_value("product low", product[7:0], rd_data);
			check_value("dout_en", 1'b1, rd_en);
			cpu_read(16'h5206, rd_data, rd_en);
			check_value("product high", product[15:8], rd_data);
			check_value("dout_en", 1'b1, rd_en);
		end
		finish_test();

		start_test("mirroring");
		for (int i = 0; i < 4; i++) begin
			mirr = (i == 0) ? 8'hE4 : 8'($random(seed));
			cpu_write(16'h5105, mirr);
			for (int q = 0; q < 4; q++) begin
				present_ppu(14'h2000 | (14'(q) << 10) | 14'h0123);
				check_value("vram_a10", mirr[2 * q], vram_a10_o);
				check_value("vram_ce", !mirr[2 * q + 1], vram_ce_o);
			end
		end
		finish_test();

		start_test("scanline_irq");
		cpu_write(16'h5203, 8'd3);
		cpu_write(16'h5204, 8'h80);
		repeat (4) begin
			check_value("irq before line", 1'b0, irq_o);
			ppu_scanline(14'h23C0);
		end
		check_value("irq on line", 1'b1, irq_o);
		cpu_read(16'h5204, rd_data, rd_en);
		check_value("status pending/in_frame", 2'b11, rd_data[7:6]);
		for (int k = 0; k < 6 && irq_o; k++)
			cpu_read(16'h5205, rd_data, rd_en);
		assert (!irq_o) else begin
			$display("irq_o stayed high after the status read in %s", test_name);
			errors++;
		end
		repeat (3) cpu_read(16'h5205, rd_data, rd_en);
		cpu_read(16'h5204, rd_data, rd_en);
		check_value("status after idle", 2'b00, rd_data[7:6]);
		finish_test();

		$display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== hdl/mmc5.sv ====
// MMC5 mapper core joining the register block, PRG and CHR mapping and scanline IRQ
`timescale 1ns/1ps

module mmc5 (
	input  logic                 clk,
	input  logic                 arst_n_i,
	input  logic                 cpu_ce_i,
	input  logic                 cpu_wr_i,
	input  logic                 cpu_rd_i,
	input  mmc5_pkg::cpu_addr_t  cpu_addr_i,
	input  mmc5_pkg::byte_t      cpu_din_i,
	output mmc5_pkg::byte_t      cpu_dout_o,
	output logic                 cpu_dout_en_o,
	output mmc5_pkg::prg_addr_t  prg_addr_o,
	output logic                 prg_allow_o,
	input  mmc5_pkg::ppu_addr_t  ppu_addr_i,
	input  logic                 ppu_rd_i,
	output mmc5_pkg::chr_addr_t  chr_addr_o,
	output logic                 vram_a10_o,
	output logic                 vram_ce_o,
	output logic                 irq_o
);

	logic                       in_frame;
	logic                       irq_pending;
	logic                       sprite_fetch;
	logic                       status_read;
	logic [1:0]                 prg_mode;
	logic [1:0]                 chr_mode;
	logic                       prg_ram_we;
	logic [2:0]                 prg_ram_bank;
	mmc5_pkg::prg_bank_t        prg_bank_0;
	mmc5_pkg::prg_bank_t        prg_bank_1;
	mmc5_pkg::prg_bank_t        prg_bank_2;
	mmc5_pkg::prg_bank_t        prg_bank_3;
	mmc5_pkg::chr_bank_t [11:0] chr_bank;
	mmc5_pkg::byte_t            mirroring;
	logic                       chr_last;
	logic                       sprite16;
	logic                       rendering;
	mmc5_pkg::scanline_t        irq_scanline;

	mmc5_regs u_regs (
		.clk            (clk),
		.arst_n_i       (arst_n_i),
		.cpu_ce_i       (cpu_ce_i),
		.cpu_wr_i       (cpu_wr_i),
		.cpu_rd_i       (cpu_rd_i),
		.cpu_addr_i     (cpu_addr_i),
		.cpu_din_i      (cpu_din_i),
		.in_frame_i     (in_frame),
		.irq_pending_i  (irq_pending),
		.cpu_dout_o     (cpu_dout_o),
		.cpu_dout_en_o  (cpu_dout_en_o),
		.status_read_o  (status_read),
		.prg_mode_o     (prg_mode),
		.chr_mode_o     (chr_mode),
		.prg_ram_we_o   (prg_ram_we),
		.prg_ram_bank_o (prg_ram_bank),
		.prg_bank_0_o   (prg_bank_0),
		.prg_bank_1_o   (prg_bank_1),
		.prg_bank_2_o   (prg_bank_2),
		.prg_bank_3_o   (prg_bank_3),
		.chr_bank_o     (chr_bank),
		.mirroring_o    (mirroring),
		.chr_last_o     (chr_last),
		.sprite16_o     (sprite16),
		.rendering_o    (rendering),
		.irq_scanline_o (irq_scanline),
		.irq_o          (irq_o)
	);

	mmc5_prg_map u_prg_map (
		.cpu_addr_i     (cpu_addr_i),
		.cpu_wr_i       (cpu_wr_i),
		.prg_mode_i     (prg_mode),
		.prg_ram_bank_i (prg_ram_bank),
		.prg_bank_0_i   (prg_bank_0),
		.prg_bank_1_i   (prg_bank_1),
		.prg_bank_2_i   (prg_bank_2),
		.prg_bank_3_i   (prg_bank_3),
		.prg_ram_we_i   (prg_ram_we),
		.prg_addr_o     (prg_addr_o),
		.prg_allow_o    (prg_allow_o)
	);

	mmc5_chr_map u_chr_map (
		.ppu_addr_i     (ppu_addr_i),
		.chr_mode_i     (chr_mode),
		.chr_bank_i     (chr_bank),
		.mirroring_i    (mirroring),
		.chr_last_i     (chr_last),
		.sprite16_i     (sprite16),
		.rendering_i    (rendering),
		.in_frame_i     (in_frame),
		.sprite_fetch_i (sprite_fetch),
		.chr_addr_o     (chr_addr_o),
		.vram_a10_o     (vram_a10_o),
		.vram_ce_o      (vram_ce_o)
	);

	mmc5_scanline_irq u_scanline_irq (
		.clk            (clk),
		.arst_n_i       (arst_n_i),
		.cpu_ce_i       (cpu_ce_i),
		.cpu_rd_i       (cpu_rd_i),
		.cpu_addr_i     (cpu_addr_i),
		.ppu_addr_i     (ppu_addr_i),
		.ppu_rd_i       (ppu_rd_i),
		.status_read_i  (status_read),
		.irq_scanline_i (irq_scanline),
		.in_frame_o     (in_frame),
		.irq_pending_o  (irq_pending),
		.sprite_fetch_o (sprite_fetch)
	);

endmodule

// ==== hdl/mmc5_scanline_irq.sv ====
// MMC5 scanline detector tracking in-frame, scanline count, sprite phase and IRQ pending
`timescale 1ns/1ps

module mmc5_scanline_irq (
	input  logic                 clk,
	input  logic                 arst_n_i,
	input  logic                 cpu_ce_i,
	input  logic                 cpu_rd_i,
	input  mmc5_pkg::cpu_addr_t  cpu_addr_i,
	input  mmc5_pkg::ppu_addr_t  ppu_addr_i,
	input  logic                 ppu_rd_i,
	input  logic                 status_read_i,
	input  mmc5_pkg::scanline_t  irq_scanline_i,
	output logic                 in_frame_o,
	output logic                 irq_pending_o,
	output logic                 sprite_fetch_o
);

	mmc5_pkg::frame_state_t state;
	logic                   ppu_rd_q;
	logic [11:0]            last_nt_addr;
	logic [1:0]             nt_read_cnt;
	logic [1:0]             idle_cnt;   // Strobes without a PPU read
	mmc5_pkg::scanline_t    scanline;
	mmc5_pkg::scanline_t    next_line;
	mmc5_pkg::tile_cnt_t    tile_cnt;
	logic                   last_a13;
	logic                   clr_armed;
	logic                   rd_rise;
	logic                   is_nt;
	logic                   triple;
	logic                   frame_end;

	assign in_frame_o = state == mmc5_pkg::in_frame;
	assign rd_rise    = ppu_rd_i && !ppu_rd_q;
	assign is_nt      = ppu_addr_i[13:12] == 2'b10;
	assign triple     = nt_read_cnt == mmc5_pkg::NT_REPEAT_COUNT;
	assign next_line  = scanline + 1'b1;

	// PPU gone idle, NMI vector fetch, or a count past the visible lines
	assign frame_end = in_frame_o && (
		(cpu_ce_i && !ppu_rd_i && idle_cnt == mmc5_pkg::IDLE_CE_LIMIT)
		|| (cpu_ce_i && cpu_rd_i && {cpu_addr_i[15:1], 1'b0} == mmc5_pkg::NMI_VECTOR_ADDR)
		|| (rd_rise && triple && scanline == mmc5_pkg::LAST_SCANLINE));

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state          <= mmc5_pkg::out_of_frame;
			ppu_rd_q       <= 1'b0;
			last_nt_addr   <= '0;
			nt_read_cnt    <= '0;
			idle_cnt       <= '0;
			scanline       <= '0;
			tile_cnt       <= '0;
			last_a13       <= 1'b0;
			clr_armed      <= 1'b0;
			irq_pending_o  <= 1'b0;
			sprite_fetch_o <= 1'b0;
		end else begin
			ppu_rd_q <= ppu_rd_i;

			if (rd_rise) begin
				last_nt_addr <= ppu_addr_i[11:0];
				if (!triple) begin
					nt_read_cnt <= nt_read_cnt + 1'b1;
				end else if (!in_frame_o) begin
					state    <= mmc5_pkg::in_frame;
					scanline <= '0;
					tile_cnt <= 6'd2;  // First two BG tiles were fetched on the previous line
				end else if (scanline != mmc5_pkg::LAST_SCANLINE) begin
					scanline <= next_line;
					if (next_line == irq_scanline_i)
						irq_pending_o <= 1'b1;
				end
				if (!is_nt || (nt_read_cnt != 2'd0 && last_nt_addr != ppu_addr_i[11:0]))
					nt_read_cnt <= '0;

				// Tile count advances on each pattern fetch after a nametable fetch
				last_a13 <= ppu_addr_i[13];
				if (in_frame_o) begin
					if (last_a13 && !ppu_addr_i[13])
						tile_cnt <= (tile_cnt == mmc5_pkg::LAST_SPRITE_TILE) ? '0 : tile_cnt + 1'b1;
					if (!last_a13 && ppu_addr_i[13]) begin
						if (tile_cnt == mmc5_pkg::SPRITE_PHASE_TILE)
							sprite_fetch_o <= 1'b1;
						else if (tile_cnt == 6'd0)
							sprite_fetch_o <= 1'b0;
					end
				end
			end

			if (cpu_ce_i) begin
				if (ppu_rd_i)
					idle_cnt <= '0;
				else if (in_frame_o)
					idle_cnt <= idle_cnt + 1'b1;
			end

			// Status read clears pending on the following strobe
			if (cpu_ce_i && clr_armed) begin
				irq_pending_o <= 1'b0;
				clr_armed     <= 1'b0;
			end
			if (status_read_i)
				clr_armed <= 1'b1;

			if (frame_end) begin
				state          <= mmc5_pkg::out_of_frame;
				nt_read_cnt    <= '0;
				idle_cnt       <= '0;
				irq_pending_o  <= 1'b0;
				sprite_fetch_o <= 1'b0;
			end
		end
	end

	assert property (@(posedge clk) disable iff (!arst_n_i)
		scanline <= mmc5_pkg::LAST_SCANLINE);

	// Pending only lives inside a frame
	assert property (@(posedge clk) disable iff (!arst_n_i)
		state == mmc5_pkg::out_of_frame |-> !irq_pending_o);

endmodule

// ==== hdl/mmc5_chr_map.sv ====
// MMC5 CHR banking with sprite/background bank sets and nametable mirroring
`timescale 1ns/1ps

module mmc5_chr_map (
	input  mmc5_pkg::ppu_addr_t        ppu_addr_i,
	input  logic [1:0]                 chr_mode_i,
	input  mmc5_pkg::chr_bank_t [11:0] chr_bank_i,
	input  mmc5_pkg::byte_t            mirroring_i,
	input  logic                       chr_last_i,
	input  logic                       sprite16_i,
	input  logic                       rendering_i,
	input  logic                       in_frame_i,
	input  logic                       sprite_fetch_i,
	output mmc5_pkg::chr_addr_t        chr_addr_o,
	output logic                       vram_a10_o,
	output logic                       vram_ce_o
);

	logic                set_b;
	logic [3:0]          idx;
	mmc5_pkg::chr_bank_t bank;
	logic [9:0]          sel;    // 1 kB page
	logic [1:0]          mirr;

	// Set B only serves background fetches with 8x16 sprites while rendering
	assign set_b = (in_frame_i && rendering_i) ? (!sprite_fetch_i && sprite16_i) : chr_last_i;

	always_comb begin
		case (chr_mode_i)
			2'd0: idx = set_b ? 4'd11 : 4'd7;
			2'd1: idx = set_b ? 4'd11 : {1'b0, ppu_addr_i[12], 2'b11};
			2'd2: idx = set_b ? {2'b10, ppu_addr_i[11], 1'b1} : {1'b0, ppu_addr_i[12:11], 1'b1};
			default: idx = set_b ? {2'b10, ppu_addr_i[11:10]} : {1'b0, ppu_addr_i[12:10]};
		endcase
		bank = chr_bank_i[idx];

		case (chr_mode_i)
			2'd0: sel = {bank[6:0], ppu_addr_i[12:10]};  // 8 kB
			2'd1: sel = {bank[7:0], ppu_addr_i[11:10]};  // 4 kB
			2'd2: sel = {bank[8:0], ppu_addr_i[10]};     // 2 kB
			default: sel = bank;                         // 1 kB
		endcase
	end

	assign chr_addr_o = {mmc5_pkg::CHR_BASE, sel, ppu_addr_i[9:0]};

	// Two bits per quadrant; bit 1 set means an external source, not CIRAM
	assign mirr       = mirroring_i[{ppu_addr_i[11:10], 1'b0} +: 2];
	assign vram_a10_o = mirr[0];
	assign vram_ce_o  = ppu_addr_i[13] && !mirr[1];

endmodule

// ==== hdl/mmc5_prg_map.sv ====
// MMC5 PRG banking for the four PRG modes and PRG RAM write protection
`timescale 1ns/1ps

module mmc5_prg_map (
	input  mmc5_pkg::cpu_addr_t  cpu_addr_i,
	input  logic                 cpu_wr_i,
	input  logic [1:0]           prg_mode_i,
	input  logic [2:0]           prg_ram_bank_i,
	input  mmc5_pkg::prg_bank_t  prg_bank_0_i,
	input  mmc5_pkg::prg_bank_t  prg_bank_1_i,
	input  mmc5_pkg::prg_bank_t  prg_bank_2_i,
	input  mmc5_pkg::prg_bank_t  prg_bank_3_i,
	input  logic                 prg_ram_we_i,
	output mmc5_pkg::prg_addr_t  prg_addr_o,
	output logic                 prg_allow_o
);

	mmc5_pkg::prg_bank_t sel;  // Bit 7 set selects ROM

	always_comb begin
		sel = {5'b0, prg_ram_bank_i};  // $6000-$7FFF in every mode
		if (cpu_addr_i[15]) begin
			case (prg_mode_i)
				2'd0: sel = {1'b1, prg_bank_3_i[6:2], cpu_addr_i[14:13]};  // One 32 kB bank
				2'd1: begin
					if (!cpu_addr_i[14])
						sel = {prg_bank_1_i[7:1], cpu_addr_i[13]};
					else
						sel = {1'b1, prg_bank_3_i[6:1], cpu_addr_i[13]};
				end
				2'd2: begin
					if (!cpu_addr_i[14])
						sel = {prg_bank_1_i[7:1], cpu_addr_i[13]};
					else if (!cpu_addr_i[13])
						sel = prg_bank_2_i;
					else
						sel = {1'b1, prg_bank_3_i[6:0]};
				end
				default: begin
					case (cpu_addr_i[14:13])
						2'd0:    sel = prg_bank_0_i;
						2'd1:    sel = prg_bank_1_i;
						2'd2:    sel = prg_bank_2_i;
						default: sel = {1'b1, prg_bank_3_i[6:0]};  // $E000 is always ROM
					endcase
				end
			endcase
		end
	end

	assign prg_addr_o = {sel[7] ? {2'b00, sel[6:0]} : {mmc5_pkg::PRG_RAM_BASE, sel[2:0]},
		cpu_addr_i[12:0]};

	// Reads anywhere from $6000, writes only into unlocked RAM
	assign prg_allow_o = (cpu_addr_i >= 16'h6000)
		&& (!cpu_wr_i || (!sel[7] && prg_ram_we_i));

endmodule

// ==== hdl/mmc5_regs.sv ====
// MMC5 register block with CPU write decode, bank registers, multiplier and read mux
`timescale 1ns/1ps

module mmc5_regs (
	input  logic                       clk,
	input  logic                       arst_n_i,
	input  logic                       cpu_ce_i,
	input  logic                       cpu_wr_i,
	input  logic                       cpu_rd_i,
	input  mmc5_pkg::cpu_addr_t        cpu_addr_i,
	input  mmc5_pkg::byte_t            cpu_din_i,
	input  logic                       in_frame_i,
	input  logic                       irq_pending_i,
	output mmc5_pkg::byte_t            cpu_dout_o,
	output logic                       cpu_dout_en_o,
	output logic                       status_read_o,
	output logic [1:0]                 prg_mode_o,
	output logic [1:0]                 chr_mode_o,
	output logic                       prg_ram_we_o,
	output logic [2:0]                 prg_ram_bank_o,
	output mmc5_pkg::prg_bank_t        prg_bank_0_o,
	output mmc5_pkg::prg_bank_t        prg_bank_1_o,
	output mmc5_pkg::prg_bank_t        prg_bank_2_o,
	output mmc5_pkg::prg_bank_t        prg_bank_3_o,
	output mmc5_pkg::chr_bank_t [11:0] chr_bank_o,
	output mmc5_pkg::byte_t            mirroring_o,
	output logic                       chr_last_o,
	output logic                       sprite16_o,
	output logic                       rendering_o,
	output mmc5_pkg::scanline_t        irq_scanline_o,
	output logic                       irq_o
);

	logic [9:0]      offset;
	logic            page_sel;
	logic            strobed_wr;
	logic            chr_sel;
	logic            protect_1;
	logic            protect_2;
	logic [1:0]      chr_upper;
	logic            irq_enable;
	mmc5_pkg::byte_t mul_a;
	mmc5_pkg::byte_t mul_b;
	logic [15:0]     product;

	assign offset     = cpu_addr_i[9:0];
	assign page_sel   = cpu_addr_i[15:10] == mmc5_pkg::REG_PAGE;
	assign strobed_wr = cpu_ce_i && cpu_wr_i;
	assign chr_sel    = page_sel && offset[9:4] == mmc5_pkg::REG_CHR_BANK_BASE[9:4]
		&& offset[3:0] < 4'd12;
	assign product    = mul_a * mul_b;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			prg_mode_o     <= 2'd3;
			chr_mode_o     <= '0;
			protect_1      <= 1'b0;
			protect_2      <= 1'b0;
			mirroring_o    <= '0;
			prg_ram_bank_o <= '0;
			prg_bank_0_o   <= '0;
			prg_bank_1_o   <= '0;
			prg_bank_2_o   <= '0;
			prg_bank_3_o   <= 8'h7F;  // Last bank visible at the reset vector
			chr_bank_o     <= '0;
			chr_upper      <= '0;
			chr_last_o     <= 1'b0;
			sprite16_o     <= 1'b0;
			rendering_o    <= 1'b0;
			irq_scanline_o <= '0;
			irq_enable     <= 1'b0;
			mul_a          <= '0;
			mul_b          <= '0;
			status_read_o  <= 1'b0;
		end else begin
			if (strobed_wr && page_sel) begin
				case (offset)
					mmc5_pkg::REG_PRG_MODE:     prg_mode_o <= cpu_din_i[1:0];
					mmc5_pkg::REG_CHR_MODE:     chr_mode_o <= cpu_din_i[1:0];
					mmc5_pkg::REG_PROTECT_1:    protect_1 <= cpu_din_i[1:0] == 2'b10;
					mmc5_pkg::REG_PROTECT_2:    protect_2 <= cpu_din_i[1:0] == 2'b01;
					mmc5_pkg::REG_MIRRORING:    mirroring_o <= cpu_din_i;
					mmc5_pkg::REG_PRG_RAM_BANK: prg_ram_bank_o <= cpu_din_i[2:0];
					mmc5_pkg::REG_PRG_BANK_0:   prg_bank_0_o <= cpu_din_i;
					mmc5_pkg::REG_PRG_BANK_1:   prg_bank_1_o <= cpu_din_i;
					mmc5_pkg::REG_PRG_BANK_2:   prg_bank_2_o <= cpu_din_i;
					mmc5_pkg::REG_PRG_BANK_3:   prg_bank_3_o <= cpu_din_i;
					mmc5_pkg::REG_CHR_UPPER:    chr_upper <= cpu_din_i[1:0];
					mmc5_pkg::REG_IRQ_SCANLINE: irq_scanline_o <= cpu_din_i;
					mmc5_pkg::REG_IRQ_STATUS:   irq_enable <= cpu_din_i[7];
					mmc5_pkg::REG_MUL_A:        mul_a <= cpu_din_i;
					mmc5_pkg::REG_MUL_B:        mul_b <= cpu_din_i;
					default: ;
				endcase
				if (chr_sel) begin
					chr_bank_o[offset[3:0]] <= {chr_upper, cpu_din_i};
					chr_last_o <= offset[3];  // Set B lives at $5128-$512B
				end
			end

			// PPU register snoops
			if (strobed_wr && cpu_addr_i == mmc5_pkg::PPU_CTRL_ADDR)
				sprite16_o <= cpu_din_i[5];
			if (strobed_wr && cpu_addr_i == mmc5_pkg::PPU_MASK_ADDR)
				rendering_o <= |cpu_din_i[4:3];  // BG or sprites enabled

			// With 8x8 sprites only set A is ever used
			if (cpu_ce_i && !sprite16_o)
				chr_last_o <= 1'b0;

			status_read_o <= cpu_ce_i && cpu_rd_i && page_sel
				&& offset == mmc5_pkg::REG_IRQ_STATUS;
		end
	end

	assign prg_ram_we_o = protect_1 && protect_2;
	assign irq_o        = irq_pending_i && irq_enable;

	// Readable registers; everything else is left to open bus
	always_comb begin
		cpu_dout_o    = 8'hFF;
		cpu_dout_en_o = 1'b0;
		if (page_sel) begin
			case (offset)
				mmc5_pkg::REG_IRQ_STATUS: begin
					cpu_dout_o    = {irq_pending_i, in_frame_i, 6'b111111};
					cpu_dout_en_o = 1'b1;
				end
				mmc5_pkg::REG_MUL_A: begin
					cpu_dout_o    = product[7:0];
					cpu_dout_en_o = 1'b1;
				end
				mmc5_pkg::REG_MUL_B: begin
					cpu_dout_o    = product[15:8];
					cpu_dout_en_o = 1'b1;
				end
				default: ;
			endcase
		end
	end

	// A mode change always traces back to a strobed CPU write
	assert property (@(posedge clk) disable iff (!arst_n_i)
		$changed(prg_mode_o) |-> $past(cpu_ce_i && cpu_wr_i));

endmodule

// ==== hdl/mmc5_pkg.sv ====
// MMC5 mapper shared types, register offsets and detector constants
package mmc5_pkg;

	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  byte_t;
	typedef logic [21:0] prg_addr_t;
	typedef logic [21:0] chr_addr_t;
	typedef logic [13:0] ppu_addr_t;
	typedef logic [7:0]  prg_bank_t;
	typedef logic [9:0]  chr_bank_t;  // Includes the two upper bits from $5130
	typedef logic [7:0]  scanline_t;
	typedef logic [5:0]  tile_cnt_t;

	typedef enum logic {
		out_of_frame,
		in_frame
	} frame_state_t;

	localparam logic [5:0] REG_PAGE = 6'b010100;  // $5000-$53FF

	// Offsets within the register page
	localparam logic [9:0] REG_PRG_MODE      = 10'h100;
	localparam logic [9:0] REG_CHR_MODE      = 10'h101;
	localparam logic [9:0] REG_PROTECT_1     = 10'h102;
	localparam logic [9:0] REG_PROTECT_2     = 10'h103;
	localparam logic [9:0] REG_MIRRORING     = 10'h105;
	localparam logic [9:0] REG_PRG_RAM_BANK  = 10'h113;
	localparam logic [9:0] REG_PRG_BANK_0    = 10'h114;
	localparam logic [9:0] REG_PRG_BANK_1    = 10'h115;
	localparam logic [9:0] REG_PRG_BANK_2    = 10'h116;
	localparam logic [9:0] REG_PRG_BANK_3    = 10'h117;
	localparam logic [9:0] REG_CHR_BANK_BASE = 10'h120;  // Twelve banks $5120-$512B
	localparam logic [9:0] REG_CHR_UPPER     = 10'h130;
	localparam logic [9:0] REG_IRQ_SCANLINE  = 10'h203;
	localparam logic [9:0] REG_IRQ_STATUS    = 10'h204;
	localparam logic [9:0] REG_MUL_A         = 10'h205;
	localparam logic [9:0] REG_MUL_B         = 10'h206;

	localparam cpu_addr_t PPU_CTRL_ADDR   = 16'h2000;
	localparam cpu_addr_t PPU_MASK_ADDR   = 16'h2001;
	localparam cpu_addr_t NMI_VECTOR_ADDR = 16'hFFFA;

	localparam scanline_t  LAST_SCANLINE     = 8'd239;
	localparam tile_cnt_t  LAST_SPRITE_TILE  = 6'd41;
	localparam tile_cnt_t  SPRITE_PHASE_TILE = 6'd34;
	localparam logic [1:0] NT_REPEAT_COUNT   = 2'd3;
	localparam logic [1:0] IDLE_CE_LIMIT     = 2'd2;

	localparam logic [5:0] PRG_RAM_BASE = 6'b11_1100;  // Save RAM region in PRG space
	localparam logic [1:0] CHR_BASE     = 2'b10;

endpackage
